//--- hw/acq_macros.svh
`ifndef ACQ_MACROS_SVH
`define ACQ_MACROS_SVH

//--------------------------------------------------------------------------
// buffer geometry
//--------------------------------------------------------------------------

// ram address bits
`define ACQ_ADDR_W 8
// entries kept in the circular buffer, 2**ACQ_ADDR_W
`define ACQ_DEPTH 256
// data width of one block ram slice
`define ACQ_SLICE_W 32

//--------------------------------------------------------------------------
// front end
//--------------------------------------------------------------------------

// one bit per antenna in each real and imaginary word
`define ACQ_ANTENNAS 24

`endif

//--- hw/acq_pkg.sv
`default_nettype none
`include "acq_macros.svh"

package acq_pkg;

   //-----------------------------------------------------------------------
   // captured payload
   //-----------------------------------------------------------------------

   // one sign bit per antenna
   typedef logic [`ACQ_ANTENNAS-1:0] antenna_word_t;

   // complex sample across all antennas
   typedef struct packed {
      antenna_word_t re;         // real parts
      antenna_word_t im;         // imaginary parts
   } sample_t;                   // 48 bits total

   // cycle count at capture
   typedef logic [31:0] stamp_t;  // free running, wraps

   //-----------------------------------------------------------------------
   // note that the sample ram packs re above im, so slice 0 holds
   // im plus the low byte of re and slice 1 holds the rest
   //-----------------------------------------------------------------------

endpackage

`default_nettype wire

//--- hw/buf_pkg.sv
`default_nettype none
`include "acq_macros.svh"

package buf_pkg;

   typedef logic [`ACQ_ADDR_W-1:0] addr_t;   // ram address
   typedef logic [`ACQ_ADDR_W:0]   fill_t;   // 0 to depth inclusive

   typedef struct packed {
      logic             strobe;   // one cycle per sample
      acq_pkg::sample_t sample;
   } cap_in_t;                    // 49 bits

   typedef struct packed {
      logic  strobe;              // one cycle per request
      addr_t index;               // 0 is the oldest entry
   } rd_req_t;                    // 9 bits

   typedef struct packed {
      logic             strobe;   // one cycle after the request
      logic             miss;     // index was at or above fill
      acq_pkg::sample_t sample;   // zero on a miss
      acq_pkg::stamp_t  stamp;    // zero on a miss
   } rd_rsp_t;                    // 82 bits

   typedef struct packed {
      logic             enable;
      addr_t            address;
      acq_pkg::sample_t sample;   // to sample ram
      acq_pkg::stamp_t  stamp;    // to stamp ram
   } wr_cmd_t;                    // 89 bits

endpackage

`default_nettype wire

//--- hw/ramb8x32_sdp.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_macros.svh"

module ramb8x32_sdp (
   input  wire                     RCLK,
   input  wire                     we,      // write port
   input  wire buf_pkg::addr_t     waddr,
   input  wire [`ACQ_SLICE_W-1:0]  di,
   input  wire                     ce,      // read port
   input  wire buf_pkg::addr_t     raddr,
   output logic [`ACQ_SLICE_W-1:0] dout
);

   //-----------------------------------------------------------------------
   // behavioural 256 x 32 simple dual port block
   //-----------------------------------------------------------------------

   logic [`ACQ_SLICE_W-1:0] mem [`ACQ_DEPTH];   // one word per address

   always_ff @(posedge RCLK) begin
      if (we) begin
         mem[waddr] <= di;                       // lands at the edge
      end
   end

   // registered read port
   // a read of the word written on the same edge returns the old value
   always_ff @(posedge RCLK) begin
      if (ce) begin
         dout <= mem[raddr];                     // read first
      end                                        // holds while ce low
   end

endmodule

`default_nettype wire

//--- hw/wide_sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_macros.svh"

module wide_sdp_ram #(
   parameter type payload_t = acq_pkg::sample_t
) (
   input  wire                 RCLK,
   input  wire                 we,
   input  wire buf_pkg::addr_t waddr,
   input  wire payload_t       wdata,
   input  wire                 ce,
   input  wire buf_pkg::addr_t raddr,
   output payload_t            rdata
);

   //-----------------------------------------------------------------------
   // slice geometry
   //-----------------------------------------------------------------------

   localparam int payload_w = $bits(payload_t);
   localparam int n_slices  = (payload_w + `ACQ_SLICE_W - 1) / `ACQ_SLICE_W;
   localparam int pad_w     = n_slices * `ACQ_SLICE_W;   // whole slices

   logic [pad_w-1:0] wdata_pad;    // payload plus zero fill on top
   wire  [pad_w-1:0] rdata_pad;    // all slice outputs side by side

   always_comb begin
      wdata_pad                = '0;
      wdata_pad[payload_w-1:0] = wdata;      // lsb aligned
   end

   assign rdata = payload_t'(rdata_pad[payload_w-1:0]);   // drop pad bits

   //-----------------------------------------------------------------------
   // one block per 32 bit slice, all sharing address and enables
   //-----------------------------------------------------------------------

   for (genvar g = 0; g < n_slices; g++) begin : g_slice
      ramb8x32_sdp slice_i (
         .RCLK  (RCLK),
         .we    (we),
         .waddr (waddr),
         .di    (wdata_pad[g*`ACQ_SLICE_W +: `ACQ_SLICE_W]),
         .ce    (ce),
         .raddr (raddr),
         .dout  (rdata_pad[g*`ACQ_SLICE_W +: `ACQ_SLICE_W])
      );
   end

endmodule

`default_nettype wire

//--- hw/capture_writer.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_macros.svh"

module capture_writer (
   input  wire                   RCLK,
   input  wire                   rst_n,
   input  wire buf_pkg::cap_in_t cap,
   output buf_pkg::wr_cmd_t      wr,
   output buf_pkg::addr_t        wr_ptr,   // next slot to write
   output buf_pkg::fill_t        fill      // entries held
);

   acq_pkg::stamp_t stamp_cnt;   // cycles since reset
   logic            full;

   assign full = (fill == buf_pkg::fill_t'(`ACQ_DEPTH));

   //-----------------------------------------------------------------------
   // timestamp counter
   //-----------------------------------------------------------------------

   // held at all ones in reset so the first cycle after release reads 0
   always_ff @(posedge RCLK) begin
      if (!rst_n) begin
         stamp_cnt <= '1;
      end else begin
         stamp_cnt <= stamp_cnt + 1'b1;        // free running
      end
   end

   //-----------------------------------------------------------------------
   // write pointer and occupancy
   //-----------------------------------------------------------------------

   always_ff @(posedge RCLK) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         fill   <= '0;
      end else if (cap.strobe) begin
         wr_ptr <= wr_ptr + 1'b1;              // wraps at depth
         if (!full) begin
            fill <= fill + 1'b1;               // saturates at depth
         end                                   // full means oldest is overwritten
      end
   end

   // write goes out in the strobe cycle and lands on the same edge
   always_comb begin
      wr.enable  = cap.strobe;
      wr.address = wr_ptr;                     // pre-advance pointer
      wr.sample  = cap.sample;
      wr.stamp   = stamp_cnt;                  // count of the strobe cycle
   end

endmodule

`default_nettype wire

//--- hw/readout_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_macros.svh"

module readout_sequencer (
   input  wire                   RCLK,
   input  wire                   rst_n,
   input  wire buf_pkg::rd_req_t req,
   input  wire buf_pkg::addr_t   wr_ptr,
   input  wire buf_pkg::fill_t   fill,
   output logic                  ce,         // ram read enable
   output buf_pkg::addr_t        raddr,
   input  wire acq_pkg::sample_t sample_q,   // sample ram output
   input  wire acq_pkg::stamp_t  stamp_q,    // stamp ram output
   output buf_pkg::rd_rsp_t      rsp
);

   buf_pkg::addr_t oldest;      // slot of index 0
   logic           hit;         // index below fill
   logic           strobe_q;    // request seen last cycle
   logic           miss_q;      // that request was out of range

   //-----------------------------------------------------------------------
   // address path, from the pre-capture pointer and fill
   //-----------------------------------------------------------------------

   // fill of 256 truncates to 0 so a full buffer starts at wr_ptr
   assign oldest = wr_ptr - fill[`ACQ_ADDR_W-1:0];
   assign hit    = ({1'b0, req.index} < fill);
   assign ce     = req.strobe & hit;           // ram only read on hits
   assign raddr  = oldest + req.index;         // mod depth

   //-----------------------------------------------------------------------
   // response, one cycle after the request
   //-----------------------------------------------------------------------

   always_ff @(posedge RCLK) begin
      if (!rst_n) begin
         strobe_q <= 1'b0;
         miss_q   <= 1'b0;
      end else begin
         strobe_q <= req.strobe;
         miss_q   <= req.strobe & ~hit;        // lines up with ram dout
      end
   end

   always_comb begin
      rsp.strobe = strobe_q;
      rsp.miss   = miss_q;
      if (miss_q) begin
         rsp.sample = '0;                      // ram held stale data
         rsp.stamp  = '0;
      end else begin
         rsp.sample = sample_q;
         rsp.stamp  = stamp_q;
      end
   end

endmodule

`default_nettype wire

//--- hw/acq_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module acq_buffer_top (
   input  wire                   RCLK,
   input  wire                   rst_n,
   input  wire buf_pkg::cap_in_t cap,    // capture strobe and sample
   input  wire buf_pkg::rd_req_t req,    // host read by relative index
   output buf_pkg::rd_rsp_t      rsp,    // one cycle after req
   output buf_pkg::fill_t        fill    // entries held
);

   buf_pkg::wr_cmd_t wr;          // shared write command
   buf_pkg::addr_t   wr_ptr;
   buf_pkg::addr_t   raddr;       // shared read address
   logic             ce;          // shared read enable
   acq_pkg::sample_t sample_q;
   acq_pkg::stamp_t  stamp_q;

   //-----------------------------------------------------------------------
   // write side
   //-----------------------------------------------------------------------

   capture_writer capture_writer_i (
      .RCLK   (RCLK),
      .rst_n  (rst_n),
      .cap    (cap),
      .wr     (wr),
      .wr_ptr (wr_ptr),
      .fill   (fill)
   );

   //-----------------------------------------------------------------------
   // storage, two slices for the sample and one for the stamp
   //-----------------------------------------------------------------------

   wide_sdp_ram #(.payload_t(acq_pkg::sample_t)) sample_ram (
      .RCLK  (RCLK),
      .we    (wr.enable),
      .waddr (wr.address),
      .wdata (wr.sample),
      .ce    (ce),
      .raddr (raddr),
      .rdata (sample_q)
   );

   wide_sdp_ram #(.payload_t(acq_pkg::stamp_t)) stamp_ram (
      .RCLK  (RCLK),
      .we    (wr.enable),
      .waddr (wr.address),
      .wdata (wr.stamp),
      .ce    (ce),
      .raddr (raddr),
      .rdata (stamp_q)
   );

   //-----------------------------------------------------------------------
   // read side
   //-----------------------------------------------------------------------

   readout_sequencer readout_sequencer_i (
      .RCLK     (RCLK),
      .rst_n    (rst_n),
      .req      (req),
      .wr_ptr   (wr_ptr),
      .fill     (fill),
      .ce       (ce),
      .raddr    (raddr),
      .sample_q (sample_q),
      .stamp_q  (stamp_q),
      .rsp      (rsp)
   );

endmodule

`default_nettype wire

//--- bench/acq_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_macros.svh"

module acq_assertions (
   input wire                   RCLK,
   input wire                   rst_n,
   input wire buf_pkg::rd_req_t req,
   input wire buf_pkg::rd_rsp_t rsp,
   input wire buf_pkg::fill_t   fill
);

   //-----------------------------------------------------------------------
   // read response timing
   //-----------------------------------------------------------------------

   a_rsp_after_req : assert property (@(posedge RCLK) disable iff (!rst_n)
      req.strobe |=> rsp.strobe)
      else $error("no response strobe one cycle after a read request");

   a_no_spurious_rsp : assert property (@(posedge RCLK) disable iff (!rst_n)
      !req.strobe |=> !rsp.strobe)
      else $error("response strobe without a read request");

   // occupancy saturates at depth
   a_fill_max : assert property (@(posedge RCLK) disable iff (!rst_n)
      fill <= buf_pkg::fill_t'(`ACQ_DEPTH))
      else $error("fill above buffer depth");

   a_quiet_in_reset : assert property (@(negedge RCLK) !rst_n |-> !rsp.strobe)
      else $error("response strobe during reset");   // sampled mid cycle

endmodule

bind acq_buffer_top acq_assertions acq_assertions_i (
   .RCLK  (RCLK),
   .rst_n (rst_n),
   .req   (req),
   .rsp   (rsp),
   .fill  (fill)
);

`default_nettype wire

//--- bench/acq_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "acq_macros.svh"

module acq_buffer_tb;

   typedef struct packed {
      acq_pkg::sample_t sample;
      acq_pkg::stamp_t  stamp;
   } entry_t;                          // one model slot

   logic             RCLK;
   logic             rst_n;
   buf_pkg::cap_in_t cap;
   buf_pkg::rd_req_t req;
   buf_pkg::rd_rsp_t rsp;
   buf_pkg::fill_t   fill;

   logic [31:0]     lfsr_state;        // stimulus generator
   entry_t          model_q[$];        // oldest at the front
   acq_pkg::stamp_t stamp_now;         // stamp of inputs driven this cycle
   logic            exp_pending;       // request went out last cycle
   logic            exp_miss;
   entry_t          exp_entry;
   int              errors;
   int              req_cnt;
   int              resp_cnt;
   string           test_name;

   acq_buffer_top acq_buffer_top_i (
      .RCLK  (RCLK),
      .rst_n (rst_n),
      .cap   (cap),
      .req   (req),
      .rsp   (rsp),
      .fill  (fill)
   );

   always #5 RCLK = ~RCLK;             // 10 ns period

   //-----------------------------------------------------------------------
   // random stimulus from a fibonacci lfsr with taps 32 22 2 1
   //-----------------------------------------------------------------------

   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r          = {r[30:0], fb};   // one step per bit
      end
      return r;
   endfunction

   function automatic logic coin_flip();
      logic [31:0] r;
      r = lfsr_bits(1);
      return r[0];
   endfunction

   function automatic acq_pkg::sample_t random_sample();
      logic [31:0]      r;
      acq_pkg::sample_t s;
      r    = lfsr_bits(`ACQ_ANTENNAS);
      s.re = r[`ACQ_ANTENNAS-1:0];
      r    = lfsr_bits(`ACQ_ANTENNAS);
      s.im = r[`ACQ_ANTENNAS-1:0];
      return s;
   endfunction

   // index in lo .. lo+span-1
   function automatic buf_pkg::addr_t pick_index(input int lo, input int span);
      int v;
      v = lo + int'(lfsr_bits(16) % span);
      return buf_pkg::addr_t'(v);
   endfunction

   //-----------------------------------------------------------------------
   // per cycle checks at the falling edge
   //-----------------------------------------------------------------------

   task automatic check_outputs();
      if (rsp.strobe) resp_cnt++;
      if (fill !== buf_pkg::fill_t'(model_q.size())) begin
         errors++;
         $display("mismatch %s fill expected %0d actual %0d", test_name, model_q.size(), fill);
      end
      if (exp_pending && !rsp.strobe) begin
         errors++;
         $display("%s: no response strobe one cycle after a read request", test_name);
      end else if (!exp_pending && rsp.strobe) begin
         errors++;
         $display("%s: response strobe without a read request", test_name);
      end else if (exp_pending) begin
         if (rsp.miss !== exp_miss) begin
            errors++;
            $display("mismatch %s miss expected %0b actual %0b", test_name, exp_miss, rsp.miss);
         end
         if (rsp.sample !== exp_entry.sample) begin
            errors++;
            $display("mismatch %s sample expected %h actual %h", test_name,
                     exp_entry.sample, rsp.sample);
         end
         if (rsp.stamp !== exp_entry.stamp) begin
            errors++;
            $display("mismatch %s stamp expected %h actual %h", test_name,
                     exp_entry.stamp, rsp.stamp);
         end
      end
   endtask

   // check last cycle, update the model, drive the next inputs
   task automatic run_cycle(input logic cs, input acq_pkg::sample_t s,
                            input logic rs, input buf_pkg::addr_t idx);
      entry_t ent;
      @(negedge RCLK);
      stamp_now++;
      check_outputs();
      exp_pending = rs;
      if (rs) begin
         req_cnt++;
         if (int'(idx) < model_q.size()) begin
            exp_miss  = 1'b0;
            exp_entry = model_q[idx];  // pre-capture contents
         end else begin
            exp_miss  = 1'b1;
            exp_entry = '0;            // miss reads back zero
         end
      end
      if (cs) begin
         ent.sample = s;
         ent.stamp  = stamp_now;
         model_q.push_back(ent);
         if (model_q.size() > `ACQ_DEPTH) void'(model_q.pop_front());   // overwrite oldest
      end
      cap.strobe = cs;
      cap.sample = s;
      req.strobe = rs;
      req.index  = idx;
   endtask

   task automatic idle_cycle();
      run_cycle(1'b0, '0, 1'b0, '0);
   endtask

   //-----------------------------------------------------------------------
   // test sequence
   //-----------------------------------------------------------------------

   initial begin
      int             n;
      int             wait_cnt;
      buf_pkg::addr_t idx;
      lfsr_state  = 32'hbedbc8d6;
      RCLK        = 1'b0;
      rst_n       = 1'b0;
      cap         = '0;
      req         = '0;
      exp_pending = 1'b0;
      exp_miss    = 1'b0;
      exp_entry   = '0;
      errors      = 0;
      req_cnt     = 0;
      resp_cnt    = 0;
      req.strobe  = 1'b1;              // requests in reset get no response
      repeat (3) @(negedge RCLK);
      req.strobe  = 1'b0;              // quiet on the last reset edge
      @(negedge RCLK);                 // 4 cycles of reset
      rst_n     = 1'b1;
      stamp_now = '1;                  // first sampled edge still counts from reset

      test_name = "reset";
      for (int i = 0; i < 4; i++) run_cycle(1'b0, '0, 1'b1, pick_index(0, 256));

      test_name = "fill";
      n = 100 + int'(lfsr_bits(7));    // under 256
      for (int i = 0; i < n; i++) begin
         idx = '0;
         if (model_q.size() > 0) idx = pick_index(0, model_q.size());
         run_cycle(1'b1, random_sample(), coin_flip(), idx);
      end
      for (int i = 0; i < 64; i++) run_cycle(1'b0, '0, 1'b1, pick_index(0, model_q.size()));

      test_name = "out_of_range";
      for (int i = 0; i < 32; i++) begin
         run_cycle(1'b0, '0, 1'b1, pick_index(model_q.size(), 256 - model_q.size()));
      end
      run_cycle(1'b0, '0, 1'b1, 8'd255);

      test_name = "same_cycle";
      idx = buf_pkg::addr_t'(model_q.size());   // one past newest
      run_cycle(1'b1, random_sample(), 1'b1, idx);   // still a miss
      run_cycle(1'b0, '0, 1'b1, idx);                // now the new sample
      run_cycle(1'b1, random_sample(), 1'b1, '0);

      test_name = "wrap";
      n = 300 + int'(lfsr_bits(6));
      for (int i = 0; i < n; i++) begin
         run_cycle(1'b1, random_sample(), coin_flip(), pick_index(0, model_q.size()));
      end
      run_cycle(1'b0, '0, 1'b1, 8'd0);          // oldest survivor
      run_cycle(1'b0, '0, 1'b1, 8'd255);        // newest

      test_name = "full_same_cycle";
      for (int i = 0; i < 8; i++) run_cycle(1'b1, random_sample(), 1'b1, 8'd0);
      run_cycle(1'b1, random_sample(), 1'b1, 8'd255);
      run_cycle(1'b0, '0, 1'b1, 8'd255);

      test_name = "random";
      for (int i = 0; i < 2000; i++) begin
         run_cycle(coin_flip(), random_sample(), coin_flip(), pick_index(0, 256));
      end

      // drain the last response
      wait_cnt = 0;
      while ((exp_pending || resp_cnt != req_cnt) && wait_cnt < 16) begin
         idle_cycle();
         wait_cnt++;
      end
      if (resp_cnt != req_cnt) begin
         errors++;
         $display("timed out waiting for responses, %0d requests but %0d responses",
                  req_cnt, resp_cnt);
      end

      $display("errors %0d, requests %0d, responses %0d", errors, req_cnt, resp_cnt);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/acq_pkg.sv
hw/buf_pkg.sv
hw/ramb8x32_sdp.sv
hw/wide_sdp_ram.sv
hw/capture_writer.sv
hw/readout_sequencer.sv
hw/acq_buffer_top.sv
bench/acq_assertions.sv
bench/acq_buffer_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = acq_buffer_tb
FILELIST  = sources.f
BUILD     = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(BUILD)
